// ==== dv/hub75FrameStoreTb.sv ====
`timescale 1ns/1ps

module hub75FrameStoreTb;

    localparam int ResetCycles = 8;
    localparam int NumEntries = 12;
    localparam int NumCorners = 6;
    // four cycles for each byte write and each scan on top of reset
    localparam int CycleLimit =
        4 * (NumEntries * 2 + NumEntries * hub75Pkg::NumPlanes) + ResetCycles;

    // fixed corner and edge positions
    // two entries per address with upper before lower
    localparam logic [9:0] CornerAddr [3] = '{10'd0, 10'd1023, 10'd63};
    localparam logic [15:0] CornerValue [NumCorners] = '{
        16'hF81F, 16'h07E0, 16'h5555, 16'hAAAA, 16'h001F, 16'hFFE0
    };

    logic ClockB = 1'b0;
    logic rstN;
    logic writeValid;
    logic writeReady;
    logic [hub75Pkg::WriteAddrBits-1:0] writeAddr;
    logic [hub75Pkg::ByteBits-1:0] writeData;
    logic scanValid;
    logic scanReady;
    logic [hub75Pkg::PixelAddrBits-1:0] scanAddr;
    logic [hub75Pkg::PlaneBits-1:0] scanPlane;
    logic colourValid;
    logic colourReady;
    logic [5:0] colour;
    logic [hub75Pkg::PixelAddrBits-1:0] colourAddr;
    logic [hub75Pkg::PlaneBits-1:0] colourPlane;

    // stimulus table of subpanel and pixel address with the pixel value
    logic tableSub [NumEntries];
    logic [hub75Pkg::PixelAddrBits-1:0] tableAddr [NumEntries];
    logic [15:0] tableValue [NumEntries];

    // reference copy of both halves updated as writes are accepted
    logic [15:0] refMem [hub75Pkg::NumSubpanels][1 << hub75Pkg::PixelAddrBits];
    // expected outputs in request order as {colour, addr, plane}
    logic [18:0] expectQ [$];

    logic [15:0] lfsrState = 16'd40628;
    int cycleCount = 0;
    int errorCount = 0;
    int checkCount = 0;
    int firstAccept;
    bit seenOutput;
    bit randomStall;

    hub75FrameStore dut0 (
        .ClockB(ClockB),
        .rstN(rstN),
        .writeValid(writeValid),
        .writeReady(writeReady),
        .writeAddr(writeAddr),
        .writeData(writeData),
        .scanValid(scanValid),
        .scanReady(scanReady),
        .scanAddr(scanAddr),
        .scanPlane(scanPlane),
        .colourValid(colourValid),
        .colourReady(colourReady),
        .colour(colour),
        .colourAddr(colourAddr),
        .colourPlane(colourPlane)
    );

    always #10 ClockB = ~ClockB;

    always @(posedge ClockB) begin
        cycleCount++;
        if (cycleCount >= CycleLimit) begin
            $display("timeout after %0d cycles, outputs stopped arriving", cycleCount);
            $display("RESULT: FAIL");
            $finish;
        end
    end

    // galois lfsr stepped once per bit handed out
    function automatic logic [15:0] takeBits(input int count);
        logic [15:0] value;
        value = '0;
        for (int i = 0; i < count; i++) begin
            value = {value[14:0], lfsrState[0]};
            lfsrState = lfsrState[0] ? ((lfsrState >> 1) ^ 16'hB400) : (lfsrState >> 1);
        end
        return value;
    endfunction

    // RGB565 layout has red in 15:11, green in 10:5 and blue in 4:0
    // plane p takes red p, green p+1 and blue p
    function automatic logic [5:0] expectColour(input logic [15:0] up, input logic [15:0] lo,
                                                input int p);
        return {up[11+p], up[6+p], up[p], lo[11+p], lo[6+p], lo[p]};
    endfunction

    task automatic checkValue(input string name, input logic [15:0] got,
                              input logic [15:0] want);
        checkCount++;
        assert (got === want) else begin
            errorCount++;
            $display("[ERROR] %s got %h expected %h", name, got, want);
        end
    endtask

    task automatic buildTable();
        for (int e = 0; e < NumEntries; e++) begin
            tableSub[e] = 1'(e % 2);
            if (e < NumCorners) begin
                tableAddr[e] = CornerAddr[e / 2];
                tableValue[e] = CornerValue[e];
            end else begin
                // random positions stay clear of the corner addresses
                if (e % 2 == 0) begin
                    tableAddr[e] = hub75Pkg::PixelAddrBits'(16'd64 + takeBits(10) % 16'd896);
                end else begin
                    tableAddr[e] = tableAddr[e - 1];
                end
                tableValue[e] = takeBits(16);
            end
        end
    endtask

    // holds the request until accepted and then records the byte in the model
    task automatic writeByte(input logic sub, input logic [9:0] pix, input logic high,
                             input logic [7:0] data);
        @(negedge ClockB);
        writeValid = 1'b1;
        writeAddr = {sub, pix, high};
        writeData = data;
        #1;
        while (!writeReady) begin
            @(negedge ClockB);
            #1;
        end
        if (high) begin
            refMem[sub][pix][15:8] = data;
        end else begin
            refMem[sub][pix][7:0] = data;
        end
    endtask

    task automatic writeEntries(input int first, input int last);
        for (int e = first; e <= last; e++) begin
            writeByte(tableSub[e], tableAddr[e], 1'b0, tableValue[e][7:0]);
            writeByte(tableSub[e], tableAddr[e], 1'b1, tableValue[e][15:8]);
        end
        @(negedge ClockB);
        writeValid = 1'b0;
    endtask

    task automatic issueScan(input int e, input int p);
        logic [9:0] pix;
        pix = tableAddr[e];
        @(negedge ClockB);
        scanValid = 1'b1;
        scanAddr = pix;
        scanPlane = hub75Pkg::PlaneBits'(p);
        #1;
        while (!scanReady) begin
            @(negedge ClockB);
            #1;
        end
        // accepted at the coming edge where no write can land
        expectQ.push_back({expectColour(refMem[0][pix], refMem[1][pix], p), pix, 3'(p)});
        if (firstAccept < 0) begin
            firstAccept = cycleCount;
        end
    endtask

    task automatic scanEntries(input int first, input int last, input bit gaps);
        for (int e = first; e <= last; e++) begin
            for (int p = 0; p < hub75Pkg::NumPlanes; p++) begin
                // idle cycles let waiting writes through
                if (gaps && takeBits(1) != 16'd0) begin
                    @(negedge ClockB);
                    scanValid = 1'b0;
                end
                issueScan(e, p);
            end
        end
        @(negedge ClockB);
        scanValid = 1'b0;
    endtask

    // drives colourReady and checks every taken output against the queue
    task automatic watchOutputs();
        logic [18:0] expected;
        bit stageFull;
        bit outFull;
        bit stallNow;
        bit acceptNow;
        // occupancy model of the read stage and the output register
        stageFull = 1'b0;
        outFull = 1'b0;
        forever begin
            @(negedge ClockB);
            if (randomStall) begin
                colourReady = (takeBits(1) != 16'd0);
            end else begin
                colourReady = 1'b1;
            end
            #1;
            if (!rstN) begin
                stageFull = 1'b0;
                outFull = 1'b0;
            end else begin
                // a full output register that is not taken blocks new scans
                stallNow = outFull && !colourReady;
                acceptNow = scanValid && !stallNow;
                checkValue("colourValid", 16'(colourValid), 16'(outFull));
                checkValue("scanReady", 16'(scanReady), 16'(!stallNow));
                // writes lose the lanes only in scan accept cycles
                checkValue("writeReady", 16'(writeReady), 16'(!acceptNow));
                if (colourValid && !seenOutput) begin
                    seenOutput = 1'b1;
                    checkValue("first output latency", 16'(cycleCount - firstAccept), 16'd2);
                end
                if (colourValid && colourReady) begin
                    checkCount++;
                    assert (expectQ.size() != 0) else begin
                        errorCount++;
                        $display("colour output appeared with no scan outstanding");
                    end
                    if (expectQ.size() != 0) begin
                        expected = expectQ.pop_front();
                        checkValue("colour", 16'(colour), 16'(expected[18:13]));
                        checkValue("colourAddr", 16'(colourAddr), 16'(expected[12:3]));
                        checkValue("colourPlane", 16'(colourPlane), 16'(expected[2:0]));
                    end
                end
                // both stages move together unless the output is held
                if (!stallNow) begin
                    outFull = stageFull;
                    stageFull = acceptNow;
                end
            end
        end
    endtask

    task automatic waitDrain();
        while (expectQ.size() != 0) begin
            @(negedge ClockB);
        end
    endtask

    initial begin
        rstN = 1'b0;
        writeValid = 1'b0;
        writeAddr = '0;
        writeData = '0;
        scanValid = 1'b0;
        scanAddr = '0;
        scanPlane = '0;
        colourReady = 1'b1;
        firstAccept = -1;
        seenOutput = 1'b0;
        randomStall = 1'b0;
        buildTable();
        fork
            watchOutputs();
        join_none
        repeat (ResetCycles) @(posedge ClockB);
        @(negedge ClockB);
        rstN = 1'b1;
        #1;
        checkValue("colourValid", 16'(colourValid), 16'd0);
        checkValue("scanReady", 16'(scanReady), 16'd1);
        checkValue("writeReady", 16'(writeReady), 16'd1);
        // corner pixels first with nothing else running
        writeEntries(0, NumCorners - 1);
        // random pixels go in while the corners are scanned with gaps
        fork
            writeEntries(NumCorners, NumEntries - 1);
            scanEntries(0, NumCorners - 1, 1'b1);
        join
        waitDrain();
        // random output stalls over the freshly written pixels
        randomStall = 1'b1;
        scanEntries(NumCorners, NumEntries - 1, 1'b0);
        waitDrain();
        $display("checks %0d, errors %0d", checkCount, errorCount);
        if (errorCount == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

// ==== rtl/framebufferHalf.sv ====
`timescale 1ns/1ps

// storage for one subpanel, low and high byte lanes side by side
module framebufferHalf (
    input logic ClockB,
    input logic rstN,
    input logic subpanelIndex,
    pixelWriteIf.bank write,
    input logic readEnable,
    input logic [hub75Pkg::PixelAddrBits-1:0] readAddr,
    output hub75Pkg::pixelWordT pixel
);

    logic claim;
    logic [hub75Pkg::PixelAddrBits-1:0] writePixel;
    logic [hub75Pkg::PixelAddrBits-1:0] laneAddr;
    logic [1:0] laneWrite;
    logic [1:0] laneEnable;
    logic [1:0][hub75Pkg::ByteBits-1:0] laneData;
    logic primed;

    // write belongs here when the top address bit names this half
    assign claim = write.valid && write.ready
                   && (write.addr[hub75Pkg::WriteAddrBits-1] == subpanelIndex);

    // drop the byte select, keep row and column
    assign writePixel = write.addr[hub75Pkg::PixelAddrBits:1];

    // ready is low whenever a read is issued, so the two never collide
    assign laneAddr = readEnable ? readAddr : writePixel;

    // address bit 0 picks the lane
    assign laneWrite[0] = claim && !write.addr[0];
    assign laneWrite[1] = claim && write.addr[0];

    // a read opens both lanes at once
    assign laneEnable[0] = readEnable || laneWrite[0];
    assign laneEnable[1] = readEnable || laneWrite[1];

    for (genvar lane = 0; lane < hub75Pkg::BytesPerPixel; lane++) begin : gLane
        laneRam u_laneRam (
            .ClockB(ClockB),
            .enable(laneEnable[lane]),
            .writeEnable(laneWrite[lane]),
            .addr(laneAddr),
            .writeData(write.data),
            .readData(laneData[lane])
        );
    end

    // lane read registers have no reset
    // until the first read lands the word reads as zero
    always_ff @(posedge ClockB or negedge rstN) begin
        if (!rstN) begin
            primed <= 1'b0;
        end else if (readEnable) begin
            primed <= 1'b1;
        end
    end

    always_comb begin
        pixel = '0;
        if (primed) begin
            pixel.bytes = laneData;
        end
    end

endmodule

// ==== rtl/hub75FrameStore.sv ====
`timescale 1ns/1ps

// frame store for a 64x32 HUB75 panel, byte writes in, colour bits out
module hub75FrameStore (
    input logic ClockB,
    input logic rstN,
    // host byte writes
    input logic writeValid,
    output logic writeReady,
    input logic [hub75Pkg::WriteAddrBits-1:0] writeAddr,
    input logic [hub75Pkg::ByteBits-1:0] writeData,
    // scan requests
    input logic scanValid,
    output logic scanReady,
    input logic [hub75Pkg::PixelAddrBits-1:0] scanAddr,
    input logic [hub75Pkg::PlaneBits-1:0] scanPlane,
    // colour output
    output logic colourValid,
    input logic colourReady,
    output logic [5:0] colour,
    output logic [hub75Pkg::PixelAddrBits-1:0] colourAddr,
    output logic [hub75Pkg::PlaneBits-1:0] colourPlane
);

    logic stall;
    logic scanAccept;
    logic stageValid;
    logic [hub75Pkg::PlaneBits-1:0] stagePlane;
    logic [hub75Pkg::PixelAddrBits-1:0] stageAddr;
    hub75Pkg::pixelWordT halfPixel [hub75Pkg::NumSubpanels];

    // a new scan only while the output register can move
    assign scanReady = !stall;
    assign scanAccept = scanValid && scanReady;

    // read wins the single lane port, writes wait one cycle
    assign writeReady = !scanAccept;

    for (genvar half = 0; half < hub75Pkg::NumSubpanels; half++) begin : gHalf
        pixelWriteIf writeBus ();

        // same host request seen by both halves, each claims its own
        assign writeBus.valid = writeValid;
        assign writeBus.addr = writeAddr;
        assign writeBus.data = writeData;
        assign writeBus.ready = writeReady;

        framebufferHalf u_framebufferHalf (
            .ClockB(ClockB),
            .rstN(rstN),
            .subpanelIndex(1'(half)),
            .write(writeBus.bank),
            .readEnable(scanAccept),
            .readAddr(scanAddr),
            .pixel(halfPixel[half])
        );
    end

    // tag for the word at the lane outputs
    // holds with the lanes while the output register is stuck
    always_ff @(posedge ClockB or negedge rstN) begin
        if (!rstN) begin
            stageValid <= 1'b0;
            stagePlane <= '0;
            stageAddr <= '0;
        end else if (!stall) begin
            stageValid <= scanAccept;
            stagePlane <= scanPlane;
            stageAddr <= scanAddr;
        end
    end

    planeSelect u_planeSelect (
        .ClockB(ClockB),
        .rstN(rstN),
        .inValid(stageValid),
        .inPlane(stagePlane),
        .inAddr(stageAddr),
        .upper(halfPixel[0]),
        .lower(halfPixel[1]),
        .outValid(colourValid),
        .outReady(colourReady),
        .stall(stall),
        .colour(colour),
        .outAddr(colourAddr),
        .outPlane(colourPlane)
    );

endmodule

// ==== rtl/hub75Pkg.sv ====
package hub75Pkg;

    // panel geometry for a 64x32 panel driven as two 16-row halves
    localparam int PanelWidth = 64;
    localparam int PanelHalfHeight = 16;
    localparam int BytesPerPixel = 2;
    localparam int NumSubpanels = 2;

    // byte write data width
    localparam int ByteBits = 8;

    // pixel index inside one half, row * 64 + column
    localparam int PixelAddrBits = $clog2(PanelWidth * PanelHalfHeight);

    // host byte address is {subpanel, pixel, byte select}
    localparam int WriteAddrBits = $clog2(NumSubpanels) + PixelAddrBits
                                   + $clog2(BytesPerPixel);

    // bit planes for binary coded modulation, only 0..4 are legal
    localparam int NumPlanes = 5;
    localparam int PlaneBits = 3;

    // one stored pixel
    // the write side sees two bytes and the scan side sees RGB565 fields
    typedef union packed {
        // index 0 is the low byte
        logic [BytesPerPixel-1:0][ByteBits-1:0] bytes;
        struct packed {
            logic [4:0] red;
            logic [5:0] green;
            logic [4:0] blue;
        } rgb;
    } pixelWordT;

endpackage

// ==== rtl/laneRam.sv ====
`timescale 1ns/1ps

// single-port byte lane, 1024 entries
module laneRam (
    input logic ClockB,
    input logic enable,
    input logic writeEnable,
    input logic [hub75Pkg::PixelAddrBits-1:0] addr,
    input logic [hub75Pkg::ByteBits-1:0] writeData,
    output logic [hub75Pkg::ByteBits-1:0] readData
);

    logic [hub75Pkg::ByteBits-1:0] mem [(1 << hub75Pkg::PixelAddrBits)];

    // one port, so an enabled cycle either writes or reads
    // read register only moves on a read, a write leaves it alone
    always_ff @(posedge ClockB) begin
        if (enable) begin
            if (writeEnable) begin
                mem[addr] <= writeData;
            end else begin
                readData <= mem[addr];
            end
        end
    end

endmodule

// ==== rtl/pixelWriteIf.sv ====
`timescale 1ns/1ps

// one host byte write, valid/ready handshake
interface pixelWriteIf;

    logic valid;
    logic ready;
    logic [hub75Pkg::WriteAddrBits-1:0] addr;
    logic [hub75Pkg::ByteBits-1:0] data;

    // host side drives the request and watches ready
    modport host (
        output valid,
        output addr,
        output data,
        input ready
    );

    // a bank only observes, ready comes from the arbiter
    modport bank (
        input valid,
        input ready,
        input addr,
        input data
    );

endinterface

// ==== rtl/planeSelect.sv ====
`timescale 1ns/1ps

// picks the bits of one plane from both halves and registers them
module planeSelect (
    input logic ClockB,
    input logic rstN,
    input logic inValid,
    input logic [hub75Pkg::PlaneBits-1:0] inPlane,
    input logic [hub75Pkg::PixelAddrBits-1:0] inAddr,
    input hub75Pkg::pixelWordT upper,
    input hub75Pkg::pixelWordT lower,
    output logic outValid,
    input logic outReady,
    output logic stall,
    output logic [5:0] colour,
    output logic [hub75Pkg::PixelAddrBits-1:0] outAddr,
    output logic [hub75Pkg::PlaneBits-1:0] outPlane
);

    logic [hub75Pkg::PlaneBits-1:0] greenBit;
    logic planeLegal;
    logic [5:0] colourNext;
    logic load;

    // green has six bits, its plane p sits one position higher
    assign greenBit = inPlane + hub75Pkg::PlaneBits'(1);
    assign planeLegal = (inPlane < hub75Pkg::PlaneBits'(hub75Pkg::NumPlanes));

    // R1 G1 B1 from the upper half, R2 G2 B2 from the lower half, msb first
    always_comb begin
        colourNext = '0;
        if (planeLegal) begin
            colourNext = {
                upper.rgb.red[inPlane],
                upper.rgb.green[greenBit],
                upper.rgb.blue[inPlane],
                lower.rgb.red[inPlane],
                lower.rgb.green[greenBit],
                lower.rgb.blue[inPlane]
            };
        end
    end

    // register full and not taken
    assign stall = outValid && !outReady;
    // empty or being taken this cycle
    assign load = !stall;

    always_ff @(posedge ClockB or negedge rstN) begin
        if (!rstN) begin
            outValid <= 1'b0;
            colour <= '0;
            outAddr <= '0;
            outPlane <= '0;
        end else if (load) begin
            outValid <= inValid;
            colour <= colourNext;
            outAddr <= inAddr;
            outPlane <= inPlane;
        end
    end

endmodule

// ==== run.sh ====
#!/bin/sh
# build and run the frame store testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert \
    -f tb.f \
    --top-module hub75FrameStoreTb \
    -o simv

./obj_dir/simv > sim.log 2>&1 || true
cat sim.log

if grep -q "RESULT: FAIL" sim.log; then
    exit 1
fi
if ! grep -q "RESULT: PASS" sim.log; then
    exit 1
fi
exit 0

// ==== tb.f ====
rtl/hub75Pkg.sv
rtl/pixelWriteIf.sv
rtl/laneRam.sv
rtl/framebufferHalf.sv
rtl/planeSelect.sv
rtl/hub75FrameStore.sv
dv/hub75FrameStoreTb.sv
